//--- common/scopePkg.sv
`default_nettype none

package scopePkg;

	localparam int sampleWidth = 8; // adc sample bits
	localparam int numChannels = 4; // adc channels on the board
	localparam int ramWidth = 10; // sample memory address bits
	localparam int totWidth = ramWidth + 1; // msb picks tick-only counting
	localparam int holdWidth = 8; // fire hold time bits
	localparam int coinWidth = 2; // coincidence count bits
	localparam int downsampleWidth = 8; // downsample exponent bits
	localparam int maxDownsample = 22; // larger exponents get clamped
	localparam int dsCountWidth = 24; // downsample counter, room for 2^22
	localparam int dsExpWidth = $clog2(dsCountWidth); // index into the downsample counter
	localparam int rateWidth = 32; // trigger rate counter bits

	typedef logic [sampleWidth-1:0] sampleT; // one adc sample
	typedef logic [ramWidth-1:0] addrT; // one sample memory address

	// acquisition sequence
	typedef enum logic [1:0] {
		idle, // waiting for startTrigger
		preAcq, // filling the pre-trigger samples
		waitTrig, // armed, waiting for selfTrig
		postAcq // filling the post-trigger samples
	} acqStateT;

	typedef enum logic {
		fallingEdge = 1'b0, // fire on leaving the window
		risingEdge = 1'b1 // fire on entering the window
	} edgeSelT;

endpackage

`default_nettype wire

//--- src/downsampleTimer.sv
`timescale 1ns/1ps
`default_nettype none

module downsampleTimer (
	input logic clk_flash,
	input logic trigratecountreset,
	input logic [scopePkg::downsampleWidth-1:0] downsample, // log2 of the decimation
	output logic sampleTick // one sample in 2^downsample is kept
);
	import scopePkg::*;

	logic [dsCountWidth-1:0] dsCount; // free running, restarts at 1
	logic [dsExpWidth-1:0] dsExp; // clamped exponent

	// exponents past the counter range would never tick
	assign dsExp = (downsample > downsampleWidth'(maxDownsample)) ?
		dsExpWidth'(maxDownsample) : dsExpWidth'(downsample);

	assign sampleTick = (downsample == '0) || dsCount[dsExp]; // every cycle at exponent 0

	always_ff @(posedge clk_flash) begin
		if (trigratecountreset) begin
			dsCount <= dsCountWidth'(1); // first tick 2^k-1 cycles out
		end else if (sampleTick) begin
			dsCount <= dsCountWidth'(1); // restart the period
		end else begin
			dsCount <= dsCount + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- trigger/channelDiscriminator.sv
`timescale 1ns/1ps
`default_nettype none

module channelDiscriminator (
	input logic clk_flash,
	input logic trigratecountreset,
	input scopePkg::sampleT sample, // raw adc input
	input scopePkg::sampleT threshLow, // window bottom, inclusive
	input scopePkg::sampleT threshHigh, // window top, inclusive
	input scopePkg::edgeSelT edgeSel, // enter or leave the window
	input logic [scopePkg::totWidth-1:0] totSetting, // time over threshold, msb = tick only
	input logic sampleTick, // downsample strobe
	output scopePkg::sampleT dout, // registered sample
	output logic fire // one cycle per accepted edge
);
	import scopePkg::*;

	logic inWindow; // sample inside the window now
	logic prevWindow; // same, one sample earlier
	logic levelNow; // the selected side of the window, now
	logic levelPrev; // the selected side, one sample earlier
	logic edgeHit; // selected edge seen this cycle
	logic [ramWidth-1:0] totLimit; // duration the level must exceed
	logic tickOnly; // count only on downsample ticks
	logic totStep; // duration counter may advance this cycle
	logic [totWidth-1:0] totCount; // 0 = idle, else cycles since the edge

	assign totLimit = totSetting[ramWidth-1:0];
	assign tickOnly = totSetting[ramWidth];
	assign totStep = !tickOnly || sampleTick;

	// falling edge is the rising edge of the inverted window
	assign levelNow = (edgeSel == risingEdge) ? inWindow : !inWindow;
	assign levelPrev = (edgeSel == risingEdge) ? prevWindow : !prevWindow;
	assign edgeHit = levelNow && !levelPrev;

	always_ff @(posedge clk_flash) begin
		dout <= sample; // stage 1, also the data output
	end

	always_ff @(posedge clk_flash) begin
		if (trigratecountreset) begin
			inWindow <= 1'b0;
			prevWindow <= 1'b0;
			totCount <= '0;
			fire <= 1'b0;
		end else begin
			inWindow <= (dout >= threshLow) && (dout <= threshHigh); // stage 2
			prevWindow <= inWindow;
			if (totLimit == '0) begin
				fire <= edgeHit; // stage 3, plain edge trigger
				totCount <= '0;
			end else if (totCount != '0) begin
				if (totCount > {1'b0, totLimit}) begin
					fire <= 1'b1; // held long enough
					totCount <= '0; // fire once per edge
				end else begin
					fire <= 1'b0;
					if (totStep) begin
						if (levelNow) begin
							totCount <= totCount + 1'b1; // level still held
						end else begin
							totCount <= '0; // dropped out before the limit
						end
					end
				end
			end else begin
				fire <= 1'b0;
				if (edgeHit) begin
					totCount <= totWidth'(1); // start timing the level
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- trigger/coincidenceUnit.sv
`timescale 1ns/1ps
`default_nettype none

module coincidenceUnit (
	input logic clk_flash,
	input logic trigratecountreset,
	input logic [scopePkg::numChannels-1:0] fire, // per channel fire pulses
	input logic [scopePkg::numChannels-1:0] trigChannels, // channels allowed to trigger
	input logic [scopePkg::holdWidth-1:0] holdTime, // ticks a fire stays visible
	input logic [scopePkg::coinWidth-1:0] coinReq, // other channels needed
	input logic allowSameChan, // own earlier fire counts too
	input logic sampleTick, // hold timers count down on ticks
	output logic selfTrig, // combined trigger decision
	output logic [scopePkg::rateWidth-1:0] rateCount // selfTrig events since reset
);
	import scopePkg::*;

	logic [holdWidth-1:0] holdTimer [numChannels]; // nonzero while a fire is held
	logic [coinWidth-1:0] coinCount [numChannels]; // held channels seen by each channel
	logic [coinWidth-1:0] coinNext [numChannels]; // next coinCount
	logic [numChannels-1:0] coinMet; // channel fires with enough company

	always_comb begin
		int hits;
		hits = 0;
		for (int i = 0; i < numChannels; i++) begin
			hits = 0;
			for (int j = 0; j < numChannels; j++) begin
				if (trigChannels[j] && (holdTimer[j] != '0) && ((j != i) || allowSameChan)) begin
					hits++;
				end
			end
			// all four held with allowSameChan would wrap, so saturate
			if (hits > (2 ** coinWidth) - 1) begin
				coinNext[i] = '1;
			end else begin
				coinNext[i] = coinWidth'(hits);
			end
		end
	end

	always_comb begin
		for (int i = 0; i < numChannels; i++) begin
			coinMet[i] = trigChannels[i] && fire[i] && (coinCount[i] >= coinReq);
		end
	end

	assign selfTrig = |coinMet; // or over the enabled channels

	always_ff @(posedge clk_flash) begin
		if (trigratecountreset) begin
			for (int i = 0; i < numChannels; i++) begin
				holdTimer[i] <= '0;
				coinCount[i] <= '0;
			end
			rateCount <= '0;
		end else begin
			for (int i = 0; i < numChannels; i++) begin
				if (fire[i]) begin
					holdTimer[i] <= holdTime; // (re)arm the hold window
				end else if ((holdTimer[i] != '0) && sampleTick) begin
					holdTimer[i] <= holdTimer[i] - 1'b1;
				end
				coinCount[i] <= coinNext[i];
			end
			if (selfTrig) begin
				rateCount <= rateCount + 1'b1; // lands the clock after selfTrig
			end
		end
	end

endmodule

`default_nettype wire

//--- src/acquisitionControl.sv
`timescale 1ns/1ps
`default_nettype none

module acquisitionControl (
	input logic clk_flash,
	input logic trigratecountreset,
	input logic startTrigger, // level, looked at only in idle
	input logic selfTrig, // trigger decision
	input logic sampleTick, // downsample strobe
	input scopePkg::addrT triggerPoint, // samples kept before the trigger
	input scopePkg::addrT nsmp, // samples kept after the trigger
	output logic acquiring, // capture in progress
	output scopePkg::addrT wrAddress, // sample memory write address
	output scopePkg::addrT trigAddress, // wrAddress at the trigger
	output logic dataReady // capture complete
);
	import scopePkg::*;

	acqStateT state; // sequence position
	addrT sampleCount; // ticks taken in the current phase

	always_ff @(posedge clk_flash) begin
		if (trigratecountreset) begin
			state <= idle;
			acquiring <= 1'b0;
			dataReady <= 1'b0;
			wrAddress <= '0;
			sampleCount <= '0;
		end else begin
			case (state)
				idle: begin
					sampleCount <= '0; // each capture counts from zero
					if (startTrigger) begin
						acquiring <= 1'b1;
						dataReady <= 1'b0; // previous capture is now stale
						state <= preAcq;
					end
				end
				preAcq: begin
					if (sampleCount == triggerPoint) begin
						state <= waitTrig; // pre-trigger part is full
					end else if (sampleTick) begin
						sampleCount <= sampleCount + 1'b1;
						wrAddress <= wrAddress + 1'b1;
					end
				end
				waitTrig: begin
					// memory keeps rolling while armed
					if (sampleTick) begin
						wrAddress <= wrAddress + 1'b1;
					end
					if (selfTrig) begin
						sampleCount <= '0; // post part counts from zero
						state <= postAcq;
					end
				end
				postAcq: begin
					if (sampleCount == nsmp) begin
						acquiring <= 1'b0; // falls with dataReady rising
						dataReady <= 1'b1;
						state <= idle;
					end else if (sampleTick) begin
						sampleCount <= sampleCount + 1'b1;
						wrAddress <= wrAddress + 1'b1;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// address before any increment in the trigger cycle
	always_ff @(posedge clk_flash) begin
		if ((state == waitTrig) && selfTrig) begin
			trigAddress <= wrAddress;
		end
	end

endmodule

`default_nettype wire

//--- src/oscilloTop.sv
`timescale 1ns/1ps
`default_nettype none

module oscilloTop (
	input logic clk_flash,
	input logic trigratecountreset, // synchronous reset of all state
	input scopePkg::sampleT sample1,
	input scopePkg::sampleT sample2,
	input scopePkg::sampleT sample3,
	input scopePkg::sampleT sample4,
	input scopePkg::sampleT threshLow, // shared window bottom
	input scopePkg::sampleT threshHigh, // shared window top
	input logic [3:0] triggerType, // bit 0 picks the edge
	input logic [scopePkg::totWidth-1:0] totSetting,
	input logic [scopePkg::downsampleWidth-1:0] downsample,
	input logic [scopePkg::numChannels-1:0] trigChannels,
	input logic [scopePkg::holdWidth-1:0] holdTime,
	input logic [scopePkg::coinWidth-1:0] coinReq,
	input logic allowSameChan,
	input logic startTrigger,
	input scopePkg::addrT triggerPoint,
	input scopePkg::addrT nsmp,
	output scopePkg::sampleT dout1,
	output scopePkg::sampleT dout2,
	output scopePkg::sampleT dout3,
	output scopePkg::sampleT dout4,
	output logic acquiring,
	output scopePkg::addrT wrAddress,
	output scopePkg::addrT trigAddress,
	output logic dataReady,
	output logic [scopePkg::rateWidth-1:0] rateCount
);
	import scopePkg::*;

	sampleT sampleArr [numChannels]; // inputs gathered for the channel loop
	sampleT doutArr [numChannels]; // registered samples back out
	logic [numChannels-1:0] fire; // one pulse line per channel
	logic sampleTick; // shared downsample strobe
	logic selfTrig; // coincidence result
	edgeSelT edgeSel; // triggerType bit 0 as an edge select

	assign sampleArr = '{sample1, sample2, sample3, sample4};
	assign dout1 = doutArr[0];
	assign dout2 = doutArr[1];
	assign dout3 = doutArr[2];
	assign dout4 = doutArr[3];
	assign edgeSel = edgeSelT'(triggerType[0]); // upper type bits unused here

	downsampleTimer timer (
		.clk_flash(clk_flash),
		.trigratecountreset(trigratecountreset),
		.downsample(downsample),
		.sampleTick(sampleTick)
	);

	for (genvar i = 0; i < numChannels; i++) begin : chan
		channelDiscriminator disc (
			.clk_flash(clk_flash),
			.trigratecountreset(trigratecountreset),
			.sample(sampleArr[i]),
			.threshLow(threshLow),
			.threshHigh(threshHigh),
			.edgeSel(edgeSel),
			.totSetting(totSetting),
			.sampleTick(sampleTick),
			.dout(doutArr[i]),
			.fire(fire[i])
		);
	end

	coincidenceUnit coin (
		.clk_flash(clk_flash),
		.trigratecountreset(trigratecountreset),
		.fire(fire),
		.trigChannels(trigChannels),
		.holdTime(holdTime),
		.coinReq(coinReq),
		.allowSameChan(allowSameChan),
		.sampleTick(sampleTick),
		.selfTrig(selfTrig),
		.rateCount(rateCount)
	);

	acquisitionControl ctrl (
		.clk_flash(clk_flash),
		.trigratecountreset(trigratecountreset),
		.startTrigger(startTrigger),
		.selfTrig(selfTrig),
		.sampleTick(sampleTick),
		.triggerPoint(triggerPoint),
		.nsmp(nsmp),
		.acquiring(acquiring),
		.wrAddress(wrAddress),
		.trigAddress(trigAddress),
		.dataReady(dataReady)
	);

endmodule

`default_nettype wire

//--- bench/oscilloTb.sv
`timescale 1ns/1ps
`default_nettype none

module oscilloTb;
	import scopePkg::*;

	localparam int numRows = 7;
	localparam int resetCycles = 5;

	typedef struct packed {
		int rise, tot, ds, chans, coin, same; // trigger settings of the row
		int acq, pre, post; // capture on, triggerPoint, nsmp
		logic [63:0] pat0, pat1; // bit c set = channel 1/2 in the window on cycle c
		int len, rate, ready, wrStep; // length and expected results
	} rowT;

	logic clk_flash = 1'b0;
	logic trigratecountreset;
	sampleT smp [numChannels]; // driven samples
	sampleT lastSmp [numChannels]; // samples of the cycle before
	sampleT dout [numChannels];
	sampleT threshLow;
	sampleT threshHigh;
	logic [3:0] triggerType;
	logic [totWidth-1:0] totSetting;
	logic [downsampleWidth-1:0] downsample;
	logic [numChannels-1:0] trigChannels;
	logic [holdWidth-1:0] holdTime;
	logic [coinWidth-1:0] coinReq;
	logic allowSameChan;
	logic startTrigger;
	logic acquiring;
	logic dataReady;
	addrT triggerPoint;
	addrT nsmp;
	addrT wrAddress;
	addrT trigAddress;
	logic [rateWidth-1:0] rateCount;
	rowT rows [numRows];
	logic [15:0] lfsr = 16'd80; // noise generator state
	int errors = 0;
	int cycles = 0;
	int limit;

	oscilloTop uut (
		.clk_flash(clk_flash), .trigratecountreset(trigratecountreset),
		.sample1(smp[0]), .sample2(smp[1]), .sample3(smp[2]), .sample4(smp[3]),
		.threshLow(threshLow), .threshHigh(threshHigh), .triggerType(triggerType),
		.totSetting(totSetting), .downsample(downsample), .trigChannels(trigChannels),
		.holdTime(holdTime), .coinReq(coinReq), .allowSameChan(allowSameChan),
		.startTrigger(startTrigger), .triggerPoint(triggerPoint), .nsmp(nsmp),
		.dout1(dout[0]), .dout2(dout[1]), .dout3(dout[2]), .dout4(dout[3]),
		.acquiring(acquiring), .wrAddress(wrAddress), .trigAddress(trigAddress),
		.dataReady(dataReady), .rateCount(rateCount)
	);

	always #10 clk_flash = ~clk_flash; // 20 ns period

	always @(posedge clk_flash) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("Timeout: run still busy after %0d cycles", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // galois taps 16,14,13,11
	endfunction

	task automatic takeBits(input int n, output sampleT v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr); // one step per bit
			v = {v[sampleWidth-2:0], lfsr[0]};
		end
	endtask

	task automatic reportMismatch(input string msg);
		$display("Mismatch at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic runRow(input int r);
		rowT row;
		sampleT v;
		logic inWin;
		int prevWr;
		int trigWr;
		int rowErrors;
		row = rows[r];
		rowErrors = errors;
		trigWr = -1; // no trigger seen yet
		prevWr = 0; // wrAddress restarts at zero after reset
		@(posedge clk_flash);
		trigratecountreset <= 1'b1;
		triggerType <= 4'(row.rise);
		totSetting <= totWidth'(row.tot);
		downsample <= downsampleWidth'(row.ds);
		trigChannels <= numChannels'(row.chans);
		coinReq <= coinWidth'(row.coin);
		allowSameChan <= row.same[0];
		triggerPoint <= addrT'(row.pre);
		nsmp <= addrT'(row.post);
		repeat (resetCycles) @(posedge clk_flash);
		trigratecountreset <= 1'b0;
		for (int c = 0; c < row.len; c++) begin
			for (int ch = 0; ch < numChannels; ch++) begin
				inWin = ((ch == 0) && row.pat0[c]) || ((ch == 1) && row.pat1[c]);
				takeBits(6, v); // 0..63 keeps noise under threshLow
				smp[ch] <= inWin ? threshLow + v : v;
			end
			startTrigger <= (c == 0) && (row.acq != 0); // one cycle start level
			@(negedge clk_flash);
			for (int ch = 0; ch < numChannels; ch++) begin
				if (dout[ch] != lastSmp[ch]) begin
					reportMismatch($sformatf("dout%0d %0d, expected %0d", ch + 1,
						dout[ch], lastSmp[ch]));
				end
				lastSmp[ch] = smp[ch];
			end
			if ((rateCount != 0) && (trigWr < 0)) begin
				trigWr = prevWr; // selfTrig sat in the cycle before this step
			end
			if ((wrAddress != addrT'(prevWr)) && ((c % (1 << row.ds)) != 0)) begin
				reportMismatch($sformatf("wrAddress stepped on cycle %0d, no tick", c));
			end
			if (acquiring && dataReady) begin
				reportMismatch("acquiring and dataReady both high");
			end
			if ((row.acq != 0) && (c > 0) && !acquiring && !dataReady) begin
				reportMismatch($sformatf("acquiring low on cycle %0d before dataReady", c));
			end
			prevWr = int'(wrAddress);
			@(posedge clk_flash); // next sample goes out on this edge
		end
		@(negedge clk_flash);
		if (rateCount != row.rate) begin
			reportMismatch($sformatf("rateCount %0d, expected %0d", rateCount, row.rate));
		end
		if (dataReady != row.ready[0]) begin
			reportMismatch($sformatf("dataReady %0b, expected %0b", dataReady, row.ready[0]));
		end
		if (wrAddress != addrT'(row.wrStep)) begin
			reportMismatch($sformatf("wrAddress %0d, expected %0d", wrAddress, row.wrStep));
		end
		if ((row.acq != 0) && (trigAddress != addrT'(trigWr))) begin
			reportMismatch($sformatf("trigAddress %0d, expected %0d", trigAddress, trigWr));
		end
		$display("row %0d: %0d cycles, rateCount %0d, %0d errors", r, row.len, rateCount,
			errors - rowErrors);
	endtask

	initial begin
		trigratecountreset <= 1'b1;
		threshLow <= 8'd100;
		threshHigh <= 8'd200;
		triggerType <= 4'd1;
		totSetting <= '0;
		downsample <= '0;
		trigChannels <= '0;
		holdTime <= 8'd8; // held fires stay visible 8 ticks
		coinReq <= '0;
		allowSameChan <= 1'b0;
		startTrigger <= 1'b0;
		triggerPoint <= '0;
		nsmp <= '0;
		for (int ch = 0; ch < numChannels; ch++) begin
			smp[ch] <= '0;
			lastSmp[ch] = '0;
		end
		// rise tot ds chans coin same acq pre post pat0 pat1 len rate ready wrStep
		rows[0] = '{1, 0, 0, 1, 0, 0, 0, 0, 0, 64'h1C10C, 64'h0, 30, 3, 0, 0}; // 3 entries
		rows[1] = '{0, 0, 0, 1, 0, 0, 0, 0, 0, 64'h1C10C, 64'h0, 30, 3, 0, 0}; // 3 exits
		rows[2] = '{1, 3, 0, 1, 0, 0, 0, 0, 0, 64'h1FE1F870C, 64'h0, 50, 2, 0, 0}; // runs 2,3,6,8
		rows[3] = '{1, 0, 0, 3, 1, 0, 0, 0, 0, 64'h100004, 64'h400000, 36, 1, 0, 0};
		rows[4] = '{1, 0, 0, 1, 1, 1, 0, 0, 0, 64'h110, 64'h0, 30, 1, 0, 0}; // double pulse
		rows[5] = '{1, 0, 0, 1, 0, 0, 1, 5, 6, 64'h8000, 64'h0, 40, 1, 1, 23}; // 5+12+6
		rows[6] = '{1, 0, 1, 1, 0, 0, 1, 3, 4, 64'h100000, 64'h0, 44, 1, 1, 16}; // 3+9+4
		limit = 50;
		for (int r = 0; r < numRows; r++) begin
			limit += rows[r].len + resetCycles + 1;
		end
		for (int r = 0; r < numRows; r++) begin
			runRow(r);
		end
		$display("%0d rows run, %0d mismatches", numRows, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
common/scopePkg.sv
src/downsampleTimer.sv
trigger/channelDiscriminator.sv
trigger/coincidenceUnit.sv
src/acquisitionControl.sv
src/oscilloTop.sv
bench/oscilloTb.sv

//--- run.sh
#!/bin/sh
# build and run the oscilloscope trigger testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f project.f --top-module oscilloTb -o oscilloSim
./obj_dir/oscilloSim > sim.log
cat sim.log
if grep -qF '** FAIL **' sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation passed"
